//--- design/dmmu_defines.svh
/*
 * Width, TLB depth and privilege encoding macros for the data MMU
 */
`ifndef DMMU_DEFINES_SVH
`define DMMU_DEFINES_SVH

// Address and page geometry for Sv32
`define DMMU_VADDR_W        32
`define DMMU_PADDR_W        34
`define DMMU_PAGE_OFFSET_W  12
`define DMMU_VPN_W          10
`define DMMU_VTAG_W         20
`define DMMU_PPN_W          22
`define DMMU_PTE_W          32

// Data TLB depth
`define DMMU_TLB_ENTRIES    4

// Privilege levels
`define DMMU_PRIV_U         2'd0
`define DMMU_PRIV_S         2'd1
`define DMMU_PRIV_M         2'd3

`endif

//--- design/dmmu_pkg.sv
/*
 * Shared types for the data MMU: privilege enum, virtual address union,
 * Sv32 page-table entry and cached TLB entry
 */
`default_nettype none

`include "dmmu_defines.svh"

package dmmu_pkg;

  typedef enum logic [1:0] {
    e_priv_u = `DMMU_PRIV_U,
    e_priv_s = `DMMU_PRIV_S,
    e_priv_m = `DMMU_PRIV_M
  } priv_mode_e;

  // Tag view used for TLB lookup and fill
  typedef struct packed {
    logic [`DMMU_VTAG_W-1:0]        vtag;
    logic [`DMMU_PAGE_OFFSET_W-1:0] offset;
  } vaddr_tlb_s;

  // Two-level index view used by the walker
  typedef struct packed {
    logic [`DMMU_VPN_W-1:0]         vpn1;
    logic [`DMMU_VPN_W-1:0]         vpn0;
    logic [`DMMU_PAGE_OFFSET_W-1:0] offset;
  } vaddr_walk_s;

  typedef union packed {
    vaddr_tlb_s  tlb;
    vaddr_walk_s walk;
  } vaddr_u;

  typedef struct packed {
    logic [`DMMU_PPN_W-1:0] ppn;
    logic [1:0]             rsw;
    logic                   d;
    logic                   a;
    logic                   g;
    logic                   u;
    logic                   x;
    logic                   w;
    logic                   r;
    logic                   v;
  } pte_s;

  // Only the bits needed for the data-side permission check
  typedef struct packed {
    logic [`DMMU_PPN_W-1:0] ppn;
    logic                   u;
    logic                   w;
    logic                   d;
  } tlb_entry_s;

endpackage

`default_nettype wire

//--- design/dmmu_top.sv
/*
 * Data MMU top: controller, data TLB and page walker
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmmu_defines.svh"

module dmmu_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     cmd_v_i,
  output logic                     cmd_ready_o,
  input  logic [`DMMU_VADDR_W-1:0] cmd_vaddr_i,
  input  logic                     cmd_store_i,
  output logic                     resp_v_o,
  input  logic                     resp_ready_i,
  output logic [`DMMU_PADDR_W-1:0] resp_paddr_o,
  output logic                     resp_load_fault_o,
  output logic                     resp_store_fault_o,
  output logic                     mem_req_v_o,
  input  logic                     mem_req_ready_i,
  output logic [`DMMU_PADDR_W-1:0] mem_req_addr_o,
  input  logic                     mem_resp_v_i,
  input  logic [`DMMU_PTE_W-1:0]   mem_resp_data_i,
  input  dmmu_pkg::priv_mode_e     priv_mode_i,
  input  logic                     sum_i,
  input  logic                     satp_en_i,
  input  logic [`DMMU_PPN_W-1:0]   satp_ppn_i,
  input  logic                     sfence_i
);
  import dmmu_pkg::*;

  logic                    tlb_lookup_v;
  logic [`DMMU_VTAG_W-1:0] tlb_lookup_vtag;
  logic                    tlb_hit;
  tlb_entry_s              tlb_entry;
  logic                    walk_start;
  vaddr_u                  walk_vaddr;
  logic                    walk_done;
  logic                    walk_fault;
  logic                    fill_v;
  logic [`DMMU_VTAG_W-1:0] fill_vtag;
  tlb_entry_s              fill_entry;

  mmu_ctrl i_ctrl (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .cmd_v_i            (cmd_v_i),
    .cmd_vaddr_i        (cmd_vaddr_i),
    .cmd_store_i        (cmd_store_i),
    .resp_ready_i       (resp_ready_i),
    .priv_mode_i        (priv_mode_i),
    .sum_i              (sum_i),
    .satp_en_i          (satp_en_i),
    .tlb_hit_i          (tlb_hit),
    .tlb_entry_i        (tlb_entry),
    .walk_done_i        (walk_done),
    .walk_fault_i       (walk_fault),
    .cmd_ready_o        (cmd_ready_o),
    .resp_v_o           (resp_v_o),
    .resp_paddr_o       (resp_paddr_o),
    .resp_load_fault_o  (resp_load_fault_o),
    .resp_store_fault_o (resp_store_fault_o),
    .tlb_lookup_v_o     (tlb_lookup_v),
    .tlb_lookup_vtag_o  (tlb_lookup_vtag),
    .walk_start_o       (walk_start),
    .walk_vaddr_o       (walk_vaddr),
    .walk_store_o       ()
  );

  dtlb i_dtlb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .flush_i       (sfence_i),
    .lookup_v_i    (tlb_lookup_v),
    .lookup_vtag_i (tlb_lookup_vtag),
    .fill_v_i      (fill_v),
    .fill_vtag_i   (fill_vtag),
    .fill_entry_i  (fill_entry),
    .hit_o         (tlb_hit),
    .entry_o       (tlb_entry)
  );

  page_walker i_walker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .satp_ppn_i      (satp_ppn_i),
    .start_i         (walk_start),
    .vaddr_i         (walk_vaddr),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i),
    .done_o          (walk_done),
    .fault_o         (walk_fault),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .fill_v_o        (fill_v),
    .fill_vtag_o     (fill_vtag),
    .fill_entry_o    (fill_entry)
  );

endmodule

`default_nettype wire

//--- design/dtlb.sv
/*
 * Fully associative data TLB with registered lookup,
 * fill into first free slot or round-robin victim, and flush
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmmu_defines.svh"

module dtlb (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    flush_i,
  input  logic                    lookup_v_i,
  input  logic [`DMMU_VTAG_W-1:0] lookup_vtag_i,
  input  logic                    fill_v_i,
  input  logic [`DMMU_VTAG_W-1:0] fill_vtag_i,
  input  dmmu_pkg::tlb_entry_s    fill_entry_i,
  output logic                    hit_o,
  output dmmu_pkg::tlb_entry_s    entry_o
);
  import dmmu_pkg::*;

  localparam int unsigned idx_w_lp = $clog2(`DMMU_TLB_ENTRIES);

  logic [`DMMU_VTAG_W-1:0]      tag_r [`DMMU_TLB_ENTRIES];
  tlb_entry_s                   entry_mem [`DMMU_TLB_ENTRIES];
  logic [`DMMU_TLB_ENTRIES-1:0] valid_r;
  logic [`DMMU_TLB_ENTRIES-1:0] match;
  logic [idx_w_lp-1:0]          match_idx;
  logic [idx_w_lp-1:0]          free_idx;
  logic [idx_w_lp-1:0]          fill_idx;
  logic [idx_w_lp-1:0]          rr_ptr_r;
  logic                         free_found;

  always_comb begin
    match_idx = '0;
    for (int i = 0; i < `DMMU_TLB_ENTRIES; i++) begin
      match[i] = valid_r[i] && (tag_r[i] == lookup_vtag_i);
      if (match[i]) begin
        match_idx = idx_w_lp'(i);
      end
    end
  end

  // Lowest invalid slot wins
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = `DMMU_TLB_ENTRIES - 1; i >= 0; i--) begin
      if (!valid_r[i]) begin
        free_found = 1'b1;
        free_idx   = idx_w_lp'(i);
      end
    end
  end

  assign fill_idx = free_found ? free_idx : rr_ptr_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      rr_ptr_r <= '0;
      hit_o    <= 1'b0;
    end else begin
      hit_o <= lookup_v_i && (|match);
      if (flush_i) begin
        valid_r <= '0;
      end else if (fill_v_i) begin
        valid_r[fill_idx] <= 1'b1;
        if (!free_found) begin
          rr_ptr_r <= (rr_ptr_r == idx_w_lp'(`DMMU_TLB_ENTRIES - 1)) ? '0 : rr_ptr_r + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_v_i) begin
      tag_r[fill_idx]     <= fill_vtag_i;
      entry_mem[fill_idx] <= fill_entry_i;
    end
    if (lookup_v_i) begin
      entry_o <= entry_mem[match_idx];
    end
  end

  // Walker only fills on a miss, so a tag never lands twice
  a_match_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    lookup_v_i |-> $onehot0(match));

  a_no_fill_during_lookup: assert property (@(posedge clk_i) disable iff (reset_i)
    !(fill_v_i && lookup_v_i));

endmodule

`default_nettype wire

//--- design/mmu_ctrl.sv
/*
 * Command sequencer: TLB lookup, permission check, walk start,
 * replay after fill and the response register
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmmu_defines.svh"

module mmu_ctrl (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     cmd_v_i,
  input  logic [`DMMU_VADDR_W-1:0] cmd_vaddr_i,
  input  logic                     cmd_store_i,
  input  logic                     resp_ready_i,
  input  dmmu_pkg::priv_mode_e     priv_mode_i,
  input  logic                     sum_i,
  input  logic                     satp_en_i,
  input  logic                     tlb_hit_i,
  input  dmmu_pkg::tlb_entry_s     tlb_entry_i,
  input  logic                     walk_done_i,
  input  logic                     walk_fault_i,
  output logic                     cmd_ready_o,
  output logic                     resp_v_o,
  output logic [`DMMU_PADDR_W-1:0] resp_paddr_o,
  output logic                     resp_load_fault_o,
  output logic                     resp_store_fault_o,
  output logic                     tlb_lookup_v_o,
  output logic [`DMMU_VTAG_W-1:0]  tlb_lookup_vtag_o,
  output logic                     walk_start_o,
  output dmmu_pkg::vaddr_u         walk_vaddr_o,
  output logic                     walk_store_o
);
  import dmmu_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_lookup,
    s_walk,
    s_respond
  } state_e;

  state_e                   state_r;
  logic                     chk_r;
  logic                     resp_v_r;
  vaddr_u                   vaddr_r;
  logic                     store_r;
  logic                     xlate_en;
  logic                     eval;
  logic                     priv_fault;
  logic                     write_fault;
  logic                     fault_n;
  logic                     resp_from_lookup;
  logic                     resp_from_walk;
  logic                     resp_load;
  logic [`DMMU_PADDR_W-1:0] paddr_n;

  assign xlate_en = satp_en_i && (priv_mode_i != e_priv_m);

  // First lookup cycle strobes the TLB, second one evaluates it
  assign eval = (state_r == s_lookup) && chk_r;

  assign priv_fault  = ((priv_mode_i == e_priv_s) && !sum_i && tlb_entry_i.u)
                    || ((priv_mode_i == e_priv_u) && !tlb_entry_i.u);
  assign write_fault = store_r && (!tlb_entry_i.w || !tlb_entry_i.d);

  assign resp_from_lookup = eval && (!xlate_en || tlb_hit_i);
  assign resp_from_walk   = (state_r == s_walk) && walk_done_i && walk_fault_i;
  assign resp_load        = resp_from_lookup || resp_from_walk;
  assign fault_n          = resp_from_walk || (xlate_en && (priv_fault || write_fault));

  always_comb begin
    if (fault_n) begin
      paddr_n = '0;
    end else if (xlate_en) begin
      paddr_n = {tlb_entry_i.ppn, vaddr_r.tlb.offset};
    end else begin
      paddr_n = {{(`DMMU_PADDR_W - `DMMU_VADDR_W){1'b0}}, vaddr_r};
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= s_idle;
      chk_r    <= 1'b0;
      resp_v_r <= 1'b0;
    end else begin
      case (state_r)
        s_idle: begin
          if (cmd_v_i) begin
            chk_r   <= 1'b0;
            state_r <= s_lookup;
          end
        end
        s_lookup: begin
          if (!chk_r) begin
            chk_r <= 1'b1;
          end else if (resp_from_lookup) begin
            resp_v_r <= 1'b1;
            state_r  <= s_respond;
          end else begin
            state_r <= s_walk;
          end
        end
        s_walk: begin
          if (resp_from_walk) begin
            resp_v_r <= 1'b1;
            state_r  <= s_respond;
          end else if (walk_done_i) begin
            // Replay now that the TLB holds the page
            chk_r   <= 1'b0;
            state_r <= s_lookup;
          end
        end
        default: begin
          if (resp_ready_i) begin
            resp_v_r <= 1'b0;
            state_r  <= s_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_v_i && cmd_ready_o) begin
      vaddr_r <= cmd_vaddr_i;
      store_r <= cmd_store_i;
    end
    if (resp_load) begin
      resp_paddr_o       <= paddr_n;
      resp_load_fault_o  <= fault_n && !store_r;
      resp_store_fault_o <= fault_n && store_r;
    end
  end

  assign cmd_ready_o       = (state_r == s_idle);
  assign resp_v_o          = resp_v_r;
  assign tlb_lookup_v_o    = (state_r == s_lookup) && !chk_r && xlate_en;
  assign tlb_lookup_vtag_o = vaddr_r.tlb.vtag;
  assign walk_start_o      = eval && xlate_en && !tlb_hit_i;
  assign walk_vaddr_o      = vaddr_r;
  assign walk_store_o      = store_r;

  a_no_resp_in_walk: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == s_walk) |-> !resp_v_o);

endmodule

`default_nettype wire

//--- design/page_walker.sv
/*
 * Two-level Sv32 page table walker with memory read port,
 * PTE validity checks and TLB fill on success
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmmu_defines.svh"

module page_walker (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic [`DMMU_PPN_W-1:0]   satp_ppn_i,
  input  logic                     start_i,
  input  dmmu_pkg::vaddr_u         vaddr_i,
  input  logic                     mem_req_ready_i,
  input  logic                     mem_resp_v_i,
  input  logic [`DMMU_PTE_W-1:0]   mem_resp_data_i,
  output logic                     done_o,
  output logic                     fault_o,
  output logic                     mem_req_v_o,
  output logic [`DMMU_PADDR_W-1:0] mem_req_addr_o,
  output logic                     fill_v_o,
  output logic [`DMMU_VTAG_W-1:0]  fill_vtag_o,
  output dmmu_pkg::tlb_entry_s     fill_entry_o
);
  import dmmu_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_req,
    s_wait,
    s_done
  } state_e;

  state_e                 state_r;
  vaddr_u                 vaddr_r;
  logic [`DMMU_PPN_W-1:0] ppn_r;
  logic                   level_r;
  logic                   fault_r;
  tlb_entry_s             entry_r;
  pte_s                   pte;
  logic                   pte_bad;
  logic                   pte_leaf;
  logic                   step_fault;
  logic                   step_next;
  logic [`DMMU_VPN_W-1:0] vpn;

  assign pte      = mem_resp_data_i;
  assign pte_bad  = !pte.v || (!pte.r && pte.w);
  assign pte_leaf = pte.r || pte.x;

  // Level 1 must point onward, level 0 must be a leaf
  assign step_fault = pte_bad || (level_r ? pte_leaf : !pte_leaf);
  assign step_next  = level_r && !step_fault;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
      level_r <= 1'b1;
      fault_r <= 1'b0;
    end else begin
      case (state_r)
        s_idle: begin
          if (start_i) begin
            level_r <= 1'b1;
            state_r <= s_req;
          end
        end
        s_req: begin
          if (mem_req_ready_i) begin
            state_r <= s_wait;
          end
        end
        s_wait: begin
          if (mem_resp_v_i) begin
            if (step_next) begin
              level_r <= 1'b0;
              state_r <= s_req;
            end else begin
              fault_r <= step_fault;
              state_r <= s_done;
            end
          end
        end
        default: begin
          state_r <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && (state_r == s_idle)) begin
      vaddr_r <= vaddr_i;
      ppn_r   <= satp_ppn_i;
    end else if ((state_r == s_wait) && mem_resp_v_i && step_next) begin
      ppn_r <= pte.ppn;
    end
    if ((state_r == s_wait) && mem_resp_v_i) begin
      entry_r.ppn <= pte.ppn;
      entry_r.u   <= pte.u;
      entry_r.w   <= pte.w;
      entry_r.d   <= pte.d;
    end
  end

  assign vpn            = level_r ? vaddr_r.walk.vpn1 : vaddr_r.walk.vpn0;
  assign mem_req_v_o    = (state_r == s_req);
  assign mem_req_addr_o = {ppn_r, vpn, 2'b00};

  assign done_o       = (state_r == s_done);
  assign fault_o      = done_o && fault_r;
  assign fill_v_o     = done_o && !fault_r;
  assign fill_vtag_o  = vaddr_r.tlb.vtag;
  assign fill_entry_o = entry_r;

  a_no_start_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    start_i |-> (state_r == s_idle));

endmodule

`default_nettype wire

//--- flist.f
+incdir+design
design/dmmu_pkg.sv
design/dtlb.sv
design/page_walker.sv
design/mmu_ctrl.sv
design/dmmu_top.sv
sim/pt_mem_model.sv
sim/tb_dmmu_top.sv

//--- run.sh
#!/usr/bin/env bash
# Build the data MMU testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=sim_dmmu

if ! verilator --binary --timing --assert -f flist.f \
    --top-module tb_dmmu_top --Mdir "$build_dir" -o "$sim_bin"; then
  echo "Verilator build failed" >&2
  exit 1
fi

"./$build_dir/$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with exit status $status" >&2
  exit "$status"
fi

echo "Simulation finished with exit status 0"
exit 0

//--- sim/pt_mem_model.sv
/*
 * Page table memory model: word array, random request stalls,
 * read data one cycle after each accepted request, request counter
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmmu_defines.svh"

module pt_mem_model (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     wr_v_i,
  input  logic [`DMMU_PADDR_W-1:0] wr_addr_i,
  input  logic [`DMMU_PTE_W-1:0]   wr_data_i,
  input  logic                     req_v_i,
  input  logic [`DMMU_PADDR_W-1:0] req_addr_i,
  output logic                     req_ready_o,
  output logic                     resp_v_o,
  output logic [`DMMU_PTE_W-1:0]   resp_data_o,
  output int unsigned              req_count_o
);
  localparam int unsigned words_lp = 4096;

  logic [`DMMU_PTE_W-1:0] mem [words_lp];

  // Background of invalid PTEs, each carrying its own word index as ppn
  initial begin
    for (int i = 0; i < words_lp; i++) begin
      mem[i] = 32'(i) << 10;
    end
  end

  always @(posedge clk_i) begin
    if (reset_i) begin
      req_ready_o <= 1'b0;
      resp_v_o    <= 1'b0;
      resp_data_o <= '0;
      req_count_o <= 0;
    end else begin
      // Stall about one cycle in three
      req_ready_o <= ($urandom_range(2, 0) != 0);
      resp_v_o    <= req_v_i && req_ready_o;
      if (req_v_i && req_ready_o) begin
        // Reads above the modeled range see an invalid PTE
        resp_data_o <= (req_addr_i[`DMMU_PADDR_W-1:14] == '0) ? mem[req_addr_i[13:2]] : '0;
        req_count_o <= req_count_o + 1;
      end
      if (wr_v_i) begin
        mem[wr_addr_i[13:2]] <= wr_data_i;
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/tb_dmmu_top.sv
/*
 * Directed testbench for the data MMU: bare and M-mode access, walk and hit,
 * permissions, walk faults, flush, replacement and response back-pressure
 */
`timescale 1ns/10ps
`default_nettype none

`include "dmmu_defines.svh"

module tb_dmmu_top;
  import dmmu_pkg::*;

  // About 45 accesses of at most ~30 cycles plus table setup, with wide margin
  localparam int unsigned max_cycles_lp = 4000;

  localparam logic [7:0] f_v = 8'h01;
  localparam logic [7:0] f_r = 8'h02;
  localparam logic [7:0] f_w = 8'h04;
  localparam logic [7:0] f_u = 8'h10;
  localparam logic [7:0] f_a = 8'h40;
  localparam logic [7:0] f_d = 8'h80;
  localparam logic [7:0] f_rwd = f_v | f_r | f_w | f_a | f_d;

  localparam logic [`DMMU_PPN_W-1:0] root_ppn_lp  = 22'h001;
  localparam logic [`DMMU_PPN_W-1:0] l0_ppn_lp    = 22'h002;
  localparam logic [`DMMU_PPN_W-1:0] kern_ppn_lp  = 22'h100;
  localparam logic [`DMMU_PPN_W-1:0] user_ppn_lp  = 22'h101;
  localparam logic [`DMMU_PPN_W-1:0] ro_ppn_lp    = 22'h102;
  localparam logic [`DMMU_PPN_W-1:0] clean_ppn_lp = 22'h103;

  logic                     clk;
  logic                     reset;
  logic                     cmd_v;
  logic                     cmd_ready;
  logic [`DMMU_VADDR_W-1:0] cmd_vaddr;
  logic                     cmd_store;
  logic                     resp_v;
  logic                     resp_ready;
  logic [`DMMU_PADDR_W-1:0] resp_paddr;
  logic                     resp_lf;
  logic                     resp_sf;
  logic                     mem_req_v;
  logic                     mem_req_ready;
  logic [`DMMU_PADDR_W-1:0] mem_req_addr;
  logic                     mem_resp_v;
  logic [`DMMU_PTE_W-1:0]   mem_resp_data;
  priv_mode_e               priv_mode;
  logic                     sum;
  logic                     satp_en;
  logic [`DMMU_PPN_W-1:0]   satp_ppn;
  logic                     sfence;
  logic                     wr_v;
  logic [`DMMU_PADDR_W-1:0] wr_addr;
  logic [`DMMU_PTE_W-1:0]   wr_data;
  int unsigned              req_count;
  int unsigned              cycle_count = 0;

  dmmu_top i_dut (
    .clk_i              (clk),
    .reset_i            (reset),
    .cmd_v_i            (cmd_v),
    .cmd_ready_o        (cmd_ready),
    .cmd_vaddr_i        (cmd_vaddr),
    .cmd_store_i        (cmd_store),
    .resp_v_o           (resp_v),
    .resp_ready_i       (resp_ready),
    .resp_paddr_o       (resp_paddr),
    .resp_load_fault_o  (resp_lf),
    .resp_store_fault_o (resp_sf),
    .mem_req_v_o        (mem_req_v),
    .mem_req_ready_i    (mem_req_ready),
    .mem_req_addr_o     (mem_req_addr),
    .mem_resp_v_i       (mem_resp_v),
    .mem_resp_data_i    (mem_resp_data),
    .priv_mode_i        (priv_mode),
    .sum_i              (sum),
    .satp_en_i          (satp_en),
    .satp_ppn_i         (satp_ppn),
    .sfence_i           (sfence)
  );

  pt_mem_model i_mem (
    .clk_i       (clk),
    .reset_i     (reset),
    .wr_v_i      (wr_v),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .req_v_i     (mem_req_v),
    .req_addr_i  (mem_req_addr),
    .req_ready_o (mem_req_ready),
    .resp_v_o    (mem_resp_v),
    .resp_data_o (mem_resp_data),
    .req_count_o (req_count)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= max_cycles_lp) begin
      $display("TB FAILED");
      $fatal(1, "Timeout: the tests did not finish within %0d cycles", max_cycles_lp);
    end
  end

  task automatic step(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, actual,
               expected);
      $display("TB FAILED");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  function automatic logic [31:0] va(input logic [9:0] vpn1, input logic [9:0] vpn0,
                                     input logic [11:0] offset);
    return {vpn1, vpn0, offset};
  endfunction

  function automatic logic [`DMMU_PPN_W-1:0] spare_ppn(input logic [9:0] vpn0);
    return 22'h200 + 22'(vpn0);
  endfunction

  task automatic write_pte(input logic [21:0] table_ppn, input logic [9:0] index,
                           input logic [21:0] ppn, input logic [7:0] flags);
    wr_addr = {table_ppn, index, 2'b00};
    wr_data = {ppn, 2'b00, flags};
    wr_v    = 1'b1;
    step(1);
    wr_v    = 1'b0;
  endtask

  task automatic pulse_sfence;
    sfence = 1'b1;
    step(1);
    sfence = 1'b0;
  endtask

  task automatic send_cmd(input logic [31:0] vaddr, input logic store);
    logic taken;
    cmd_vaddr = vaddr;
    cmd_store = store;
    cmd_v     = 1'b1;
    taken     = 1'b0;
    while (!taken) begin
      taken = cmd_ready;
      step(1);
    end
    cmd_v = 1'b0;
  endtask

  // Counts cycles from the acceptance edge to resp_v
  task automatic wait_resp(output int unsigned cycles);
    cycles = 0;
    while (!resp_v) begin
      step(1);
      cycles++;
    end
  endtask

  // Faulted responses carry paddr 0, fault kind follows the command
  task automatic run_access(input logic [31:0] vaddr, input logic store,
                            input logic [33:0] xlate_paddr, input logic fault,
                            input int unsigned exp_reqs, input logic check_latency);
    int unsigned reqs_before;
    int unsigned cycles;
    logic [33:0] exp_paddr;
    exp_paddr   = fault ? 34'd0 : xlate_paddr;
    reqs_before = req_count;
    send_cmd(vaddr, store);
    wait_resp(cycles);
    check_equal(64'(resp_paddr), 64'(exp_paddr), "physical address");
    check_equal(64'(resp_lf), 64'(fault && !store), "load page fault");
    check_equal(64'(resp_sf), 64'(fault && store), "store page fault");
    check_equal(64'(req_count - reqs_before), 64'(exp_reqs), "memory request count");
    if (check_latency) begin
      check_equal(64'(cycles), 64'd2, "response latency");
    end
    step(1);
    check_equal(64'(resp_v), 64'd0, "resp_v after transfer");
  endtask

  task automatic build_tables;
    write_pte(root_ppn_lp, 10'd1, l0_ppn_lp, f_v);
    write_pte(root_ppn_lp, 10'd3, 22'h3ff, f_rwd);
    write_pte(root_ppn_lp, 10'd4, 22'h3fe, f_v | f_w);
    write_pte(l0_ppn_lp, 10'd0, kern_ppn_lp, f_rwd);
    write_pte(l0_ppn_lp, 10'd1, user_ppn_lp, f_rwd | f_u);
    write_pte(l0_ppn_lp, 10'd2, ro_ppn_lp, f_v | f_r | f_a | f_d);
    write_pte(l0_ppn_lp, 10'd3, clean_ppn_lp, f_v | f_r | f_w | f_a);
    for (int i = 4; i < 9; i++) begin
      write_pte(l0_ppn_lp, 10'(i), spare_ppn(10'(i)), f_rwd);
    end
    // Pointer where a leaf is required
    write_pte(l0_ppn_lp, 10'd9, 22'h005, f_v);
  endtask

  task automatic bare_mode;
    satp_en   = 1'b0;
    priv_mode = e_priv_s;
    run_access(32'hdead_beef, 1'b0, {2'b00, 32'hdead_beef}, 1'b0, 0, 1'b1);
    run_access(32'h8000_1004, 1'b1, {2'b00, 32'h8000_1004}, 1'b0, 0, 1'b1);
    satp_en   = 1'b1;
    priv_mode = e_priv_m;
    run_access(va(10'd1, 10'd0, 12'h123), 1'b1, {2'b00, va(10'd1, 10'd0, 12'h123)},
               1'b0, 0, 1'b1);
  endtask

  task automatic walk_then_hit;
    satp_en   = 1'b1;
    priv_mode = e_priv_s;
    sum       = 1'b0;
    pulse_sfence();
    run_access(va(10'd1, 10'd0, 12'h234), 1'b0, {kern_ppn_lp, 12'h234}, 1'b0, 2, 1'b0);
    run_access(va(10'd1, 10'd0, 12'habc), 1'b1, {kern_ppn_lp, 12'habc}, 1'b0, 0, 1'b1);
  endtask

  task automatic permission_rules;
    pulse_sfence();
    priv_mode = e_priv_u;
    run_access(va(10'd1, 10'd0, 12'h010), 1'b0, {kern_ppn_lp, 12'h010}, 1'b1, 2, 1'b0);
    run_access(va(10'd1, 10'd1, 12'h020), 1'b0, {user_ppn_lp, 12'h020}, 1'b0, 2, 1'b0);
    priv_mode = e_priv_s;
    run_access(va(10'd1, 10'd1, 12'h030), 1'b0, {user_ppn_lp, 12'h030}, 1'b1, 0, 1'b1);
    sum = 1'b1;
    run_access(va(10'd1, 10'd1, 12'h040), 1'b1, {user_ppn_lp, 12'h040}, 1'b0, 0, 1'b1);
    sum = 1'b0;
    run_access(va(10'd1, 10'd2, 12'h050), 1'b1, {ro_ppn_lp, 12'h050}, 1'b1, 2, 1'b0);
    run_access(va(10'd1, 10'd2, 12'h060), 1'b0, {ro_ppn_lp, 12'h060}, 1'b0, 0, 1'b1);
    run_access(va(10'd1, 10'd3, 12'h070), 1'b1, {clean_ppn_lp, 12'h070}, 1'b1, 2, 1'b0);
    run_access(va(10'd1, 10'd3, 12'h080), 1'b0, {clean_ppn_lp, 12'h080}, 1'b0, 0, 1'b1);
  endtask

  task automatic walk_faults;
    // Invalid root entry, twice since nothing gets cached
    run_access(va(10'd2, 10'd0, 12'h100), 1'b0, 34'd0, 1'b1, 1, 1'b0);
    run_access(va(10'd2, 10'd0, 12'h104), 1'b0, 34'd0, 1'b1, 1, 1'b0);
    run_access(va(10'd3, 10'd5, 12'h200), 1'b1, 34'd0, 1'b1, 1, 1'b0);
    run_access(va(10'd3, 10'd5, 12'h204), 1'b1, 34'd0, 1'b1, 1, 1'b0);
    run_access(va(10'd4, 10'd0, 12'h300), 1'b0, 34'd0, 1'b1, 1, 1'b0);
    run_access(va(10'd1, 10'd9, 12'h400), 1'b1, 34'd0, 1'b1, 2, 1'b0);
  endtask

  task automatic flush_and_replace;
    pulse_sfence();
    run_access(va(10'd1, 10'd4, 12'h111), 1'b0, {spare_ppn(10'd4), 12'h111}, 1'b0, 2, 1'b0);
    run_access(va(10'd1, 10'd4, 12'h222), 1'b0, {spare_ppn(10'd4), 12'h222}, 1'b0, 0, 1'b1);
    pulse_sfence();
    run_access(va(10'd1, 10'd4, 12'h333), 1'b0, {spare_ppn(10'd4), 12'h333}, 1'b0, 2, 1'b0);
    // Five pages into four slots, the fifth evicts the oldest
    pulse_sfence();
    for (int i = 4; i < 9; i++) begin
      run_access(va(10'd1, 10'(i), 12'h400), 1'b0, {spare_ppn(10'(i)), 12'h400}, 1'b0, 2,
                 1'b0);
    end
    for (int i = 5; i < 9; i++) begin
      run_access(va(10'd1, 10'(i), 12'h500), 1'b0, {spare_ppn(10'(i)), 12'h500}, 1'b0, 0,
                 1'b1);
    end
    run_access(va(10'd1, 10'd4, 12'h600), 1'b0, {spare_ppn(10'd4), 12'h600}, 1'b0, 2, 1'b0);
    run_access(va(10'd1, 10'd5, 12'h604), 1'b0, {spare_ppn(10'd5), 12'h604}, 1'b0, 2, 1'b0);
    run_access(va(10'd1, 10'd7, 12'h608), 1'b0, {spare_ppn(10'd7), 12'h608}, 1'b0, 0, 1'b1);
    run_access(va(10'd1, 10'd8, 12'h60c), 1'b0, {spare_ppn(10'd8), 12'h60c}, 1'b0, 0, 1'b1);
  endtask

  task automatic back_pressure;
    int unsigned cycles;
    logic [33:0] held_paddr;
    satp_en    = 1'b0;
    resp_ready = 1'b0;
    send_cmd(32'h0000_1234, 1'b0);
    wait_resp(cycles);
    check_equal(64'(cycles), 64'd2, "first response latency");
    held_paddr = resp_paddr;
    check_equal(64'(held_paddr), 64'h1234, "first response paddr");
    // Second command waits behind the held response
    cmd_vaddr = 32'h0000_5678;
    cmd_store = 1'b1;
    cmd_v     = 1'b1;
    repeat (6) begin
      step(1);
      check_equal(64'(resp_v), 64'd1, "resp_v held");
      check_equal(64'(resp_paddr), 64'(held_paddr), "paddr held");
      check_equal(64'(resp_lf | resp_sf), 64'd0, "faults held");
      check_equal(64'(cmd_ready), 64'd0, "cmd_ready while response waits");
    end
    resp_ready = 1'b1;
    step(1);
    check_equal(64'(resp_v), 64'd0, "resp_v after transfer");
    check_equal(64'(cmd_ready), 64'd1, "cmd_ready after transfer");
    step(1);
    cmd_v = 1'b0;
    check_equal(64'(cmd_ready), 64'd0, "second command accepted");
    wait_resp(cycles);
    check_equal(64'(cycles), 64'd2, "second response latency");
    check_equal(64'(resp_paddr), 64'h5678, "second response paddr");
    check_equal(64'(resp_sf), 64'd0, "second response store fault");
    step(1);
  endtask

  initial begin
    void'($urandom(32'h229b_9a32));
    clk        = 1'b0;
    reset      = 1'b1;
    cmd_v      = 1'b0;
    cmd_vaddr  = '0;
    cmd_store  = 1'b0;
    resp_ready = 1'b1;
    priv_mode  = e_priv_s;
    sum        = 1'b0;
    satp_en    = 1'b0;
    satp_ppn   = root_ppn_lp;
    sfence     = 1'b0;
    wr_v       = 1'b0;
    wr_addr    = '0;
    wr_data    = '0;
    step(16);
    reset = 1'b0;
    check_equal(64'(cmd_ready), 64'd1, "cmd_ready after reset");
    check_equal(64'(resp_v), 64'd0, "resp_v after reset");
    check_equal(64'(mem_req_v), 64'd0, "mem_req_v after reset");
    check_equal(64'(i_dut.i_dtlb.valid_r), 64'd0, "TLB valid bits after reset");
    build_tables();
    bare_mode();
    walk_then_hit();
    permission_rules();
    walk_faults();
    flush_and_replace();
    back_pressure();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire
